/* hw/cache_pkg.sv */
package cache_pkg;

    // Byte address as seen by the core and by the line-side ports
    typedef logic [31:0] addr_t;

    // One data word
    typedef logic [31:0] word_t;

    localparam int WORDS_PER_LINE = 4;

    // Byte offset bits inside one 16-byte line
    localparam int LINE_OFFSET_BITS = 4;

    // A cache line moves as raw bits on the memory side.
    // The caches pick and merge single words through the word view.
    // Word 0 holds the lowest address.
    typedef union packed {
        logic [WORDS_PER_LINE*32-1:0]  bits;
        word_t [WORDS_PER_LINE-1:0]    words;
    } cache_line_u;

endpackage

/* hw/main_mem.sv */
`timescale 1ns/100ps

module main_mem #(
    parameter int MEM_LINES = 256
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    req,
    input  logic                    we,
    input  cache_pkg::addr_t        addr,
    input  cache_pkg::cache_line_u  wdata,
    output logic                    ack,
    output cache_pkg::cache_line_u  rdata
);

    localparam int LINE_IDX_W = $clog2(MEM_LINES);
    localparam int WORD_SEL_W = $clog2(cache_pkg::WORDS_PER_LINE);

    cache_pkg::word_t mem_q [MEM_LINES * cache_pkg::WORDS_PER_LINE];

    logic [LINE_IDX_W-1:0] line_idx;
    logic                  access;

    assign line_idx = addr[cache_pkg::LINE_OFFSET_BITS +: LINE_IDX_W];

    // A request seen during the ack cycle is ignored
    assign access = req & ~ack;

    // Whole line written in one cycle
    always_ff @(posedge clk) begin
        if (access && we) begin
            for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
                mem_q[{line_idx, WORD_SEL_W'(w)}] <= wdata.words[w];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack   <= 1'b0;
            rdata <= '0;
        end else if (access) begin
            ack <= 1'b1;
            if (!we) begin
                for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
                    rdata.words[w] <= mem_q[{line_idx, WORD_SEL_W'(w)}];
                end
            end
        end else begin
            ack   <= 1'b0;
            rdata <= '0;
        end
    end

    // Requesters rely on ack being a single pulse
    assert property (@(posedge clk) disable iff (!arst_n) ack |=> !ack)
        else $error("main_mem: ack high in two consecutive cycles");

endmodule

/* hw/mem_arbiter.sv */
`timescale 1ns/100ps

module mem_arbiter (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    ic_req,
    input  cache_pkg::addr_t        ic_addr,
    output logic                    ic_ack,
    output cache_pkg::cache_line_u  ic_rdata,
    input  logic                    dc_req,
    input  logic                    dc_we,
    input  cache_pkg::addr_t        dc_addr,
    input  cache_pkg::cache_line_u  dc_wdata,
    output logic                    dc_ack,
    output cache_pkg::cache_line_u  dc_rdata,
    output logic                    mem_req,
    output logic                    mem_we,
    output cache_pkg::addr_t        mem_addr,
    output cache_pkg::cache_line_u  mem_wdata,
    input  logic                    mem_ack,
    input  cache_pkg::cache_line_u  mem_rdata
);

    logic own_ic_q;
    logic own_dc_q;
    logic last_dc_q;
    logic held;
    logic grant_ic;
    logic grant_dc;

    assign held = own_ic_q | own_dc_q;

    // Free port goes to a lone requester at once; on a tie the last winner yields
    assign grant_ic = own_ic_q | (~held & ic_req & (~dc_req | last_dc_q));
    assign grant_dc = own_dc_q | (~held & dc_req & (~ic_req | ~last_dc_q));

    assign mem_req   = (grant_ic & ic_req) | (grant_dc & dc_req);
    // Instruction side never writes
    assign mem_we    = grant_dc ? dc_we : 1'b0;
    assign mem_addr  = grant_dc ? dc_addr : ic_addr;
    assign mem_wdata = grant_dc ? dc_wdata : '0;

    assign ic_ack   = mem_ack & own_ic_q;
    assign dc_ack   = mem_ack & own_dc_q;
    assign ic_rdata = mem_rdata;
    assign dc_rdata = mem_rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            own_ic_q  <= 1'b0;
            own_dc_q  <= 1'b0;
            last_dc_q <= 1'b0;
        end else if (mem_ack) begin
            own_ic_q <= 1'b0;
            own_dc_q <= 1'b0;
        end else if (!held) begin
            own_ic_q <= grant_ic;
            own_dc_q <= grant_dc;
            if (grant_ic || grant_dc) begin
                last_dc_q <= grant_dc;
            end
        end
    end

    // A request that memory has taken keeps its owner until the ack
    assert property (@(posedge clk) disable iff (!arst_n)
        (mem_req && !mem_ack) |=> (own_ic_q || own_dc_q))
        else $error("mem_arbiter: memory request without an owner");

endmodule

/* hw/icache.sv */
`timescale 1ns/100ps

module icache #(
    parameter int ICACHE_LINES = 8
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    i_req,
    input  cache_pkg::addr_t        i_addr,
    output logic                    i_ack,
    output cache_pkg::word_t        i_rdata,
    output logic                    ic_req,
    output cache_pkg::addr_t        ic_addr,
    input  logic                    ic_ack,
    input  cache_pkg::cache_line_u  ic_rdata
);

    localparam int IDX_W = $clog2(ICACHE_LINES);
    localparam int SEL_W = $clog2(cache_pkg::WORDS_PER_LINE);
    localparam int TAG_W = 32 - cache_pkg::LINE_OFFSET_BITS - IDX_W;

    localparam logic [1:0] S_LOOKUP  = 2'd0;
    localparam logic [1:0] S_REFILL  = 2'd1;
    localparam logic [1:0] S_RESPOND = 2'd2;

    logic [1:0]              state_q;
    logic [ICACHE_LINES-1:0] valid_q;
    logic [TAG_W-1:0]        tag_q  [ICACHE_LINES];
    cache_pkg::cache_line_u  line_q [ICACHE_LINES];

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic [SEL_W-1:0] sel;
    logic             lookup;
    logic             hit;

    assign idx = i_addr[cache_pkg::LINE_OFFSET_BITS +: IDX_W];
    assign tag = i_addr[31 -: TAG_W];
    assign sel = i_addr[cache_pkg::LINE_OFFSET_BITS - SEL_W +: SEL_W];

    // New lookups wait out the ack cycle
    assign lookup = (state_q == S_LOOKUP) & i_req & ~i_ack;
    assign hit    = valid_q[idx] & (tag_q[idx] == tag);

    assign ic_req  = (state_q == S_REFILL);
    assign ic_addr = {i_addr[31:cache_pkg::LINE_OFFSET_BITS],
                      {cache_pkg::LINE_OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= S_LOOKUP;
            valid_q <= '0;
            i_ack   <= 1'b0;
        end else begin
            i_ack <= 1'b0;
            case (state_q)
                S_LOOKUP: begin
                    if (lookup && hit) begin
                        i_ack <= 1'b1;
                    end else if (lookup) begin
                        state_q <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    if (ic_ack) begin
                        valid_q[idx] <= 1'b1;
                        state_q      <= S_RESPOND;
                    end
                end
                S_RESPOND: begin
                    i_ack   <= 1'b1;
                    state_q <= S_LOOKUP;
                end
                default: state_q <= S_LOOKUP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_REFILL && ic_ack) begin
            line_q[idx] <= ic_rdata;
            tag_q[idx]  <= tag;
        end
        if ((lookup && hit) || state_q == S_RESPOND) begin
            i_rdata <= line_q[idx].words[sel];
        end
    end

    // Refill and response both index the arrays from the live address
    assert property (@(posedge clk) disable iff (!arst_n)
        (i_req && !i_ack) |=> $stable(i_addr))
        else $error("icache: i_addr changed while a fetch was pending");

endmodule

/* hw/dcache.sv */
`timescale 1ns/100ps

module dcache #(
    parameter int DCACHE_LINES = 8
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    d_req,
    input  logic                    d_we,
    input  cache_pkg::addr_t        d_addr,
    input  cache_pkg::word_t        d_wdata,
    output logic                    d_ack,
    output cache_pkg::word_t        d_rdata,
    output logic                    dc_req,
    output logic                    dc_we,
    output cache_pkg::addr_t        dc_addr,
    output cache_pkg::cache_line_u  dc_wdata,
    input  logic                    dc_ack,
    input  cache_pkg::cache_line_u  dc_rdata
);

    localparam int IDX_W = $clog2(DCACHE_LINES);
    localparam int SEL_W = $clog2(cache_pkg::WORDS_PER_LINE);
    localparam int TAG_W = 32 - cache_pkg::LINE_OFFSET_BITS - IDX_W;

    localparam logic [1:0] S_LOOKUP  = 2'd0;
    localparam logic [1:0] S_REFILL  = 2'd1;
    localparam logic [1:0] S_WRITE   = 2'd2;
    localparam logic [1:0] S_RESPOND = 2'd3;

    logic [1:0]              state_q;
    logic [DCACHE_LINES-1:0] valid_q;
    logic [TAG_W-1:0]        tag_q  [DCACHE_LINES];
    cache_pkg::cache_line_u  line_q [DCACHE_LINES];
    cache_pkg::cache_line_u  wbuf_q;
    cache_pkg::cache_line_u  merged;

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic [SEL_W-1:0] sel;
    logic             lookup;
    logic             hit;

    assign idx = d_addr[cache_pkg::LINE_OFFSET_BITS +: IDX_W];
    assign tag = d_addr[31 -: TAG_W];
    assign sel = d_addr[cache_pkg::LINE_OFFSET_BITS - SEL_W +: SEL_W];

    assign lookup = (state_q == S_LOOKUP) & d_req & ~d_ack;
    assign hit    = valid_q[idx] & (tag_q[idx] == tag);

    // Store word dropped into the freshly refilled line or the cached copy
    always_comb begin
        merged = (state_q == S_REFILL) ? dc_rdata : line_q[idx];
        merged.words[sel] = d_wdata;
    end

    assign dc_req   = (state_q == S_REFILL) | (state_q == S_WRITE);
    assign dc_we    = (state_q == S_WRITE);
    assign dc_addr  = {d_addr[31:cache_pkg::LINE_OFFSET_BITS],
                       {cache_pkg::LINE_OFFSET_BITS{1'b0}}};
    assign dc_wdata = wbuf_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= S_LOOKUP;
            valid_q <= '0;
            d_ack   <= 1'b0;
        end else begin
            d_ack <= 1'b0;
            case (state_q)
                S_LOOKUP: begin
                    if (lookup && hit && !d_we) begin
                        d_ack <= 1'b1;
                    end else if (lookup && hit) begin
                        state_q <= S_WRITE;
                    end else if (lookup) begin
                        state_q <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    if (dc_ack) begin
                        valid_q[idx] <= 1'b1;
                        state_q      <= d_we ? S_WRITE : S_RESPOND;
                    end
                end
                S_WRITE: begin
                    if (dc_ack) begin
                        state_q <= S_RESPOND;
                    end
                end
                default: begin
                    d_ack   <= 1'b1;
                    state_q <= S_LOOKUP;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_REFILL && dc_ack) begin
            line_q[idx] <= dc_rdata;
            tag_q[idx]  <= tag;
        end else if (state_q == S_WRITE && dc_ack) begin
            // local copy follows memory only once the write has landed
            line_q[idx] <= wbuf_q;
        end
        if ((lookup && hit && d_we) || (state_q == S_REFILL && dc_ack)) begin
            wbuf_q <= merged;
        end
        if ((lookup && hit && !d_we) || state_q == S_RESPOND) begin
            d_rdata <= line_q[idx].words[sel];
        end
    end

    // Write-through only ever sends a line that was refilled first
    assert property (@(posedge clk) disable iff (!arst_n)
        (dc_req && dc_we) |-> valid_q[idx])
        else $error("dcache: line write issued for an invalid line");

endmodule

/* hw/mem_subsys_top.sv */
`timescale 1ns/100ps

module mem_subsys_top #(
    parameter int MEM_LINES    = 256,
    parameter int ICACHE_LINES = 8,
    parameter int DCACHE_LINES = 8
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              i_req,
    input  cache_pkg::addr_t  i_addr,
    output logic              i_ack,
    output cache_pkg::word_t  i_rdata,
    input  logic              d_req,
    input  logic              d_we,
    input  cache_pkg::addr_t  d_addr,
    input  cache_pkg::word_t  d_wdata,
    output logic              d_ack,
    output cache_pkg::word_t  d_rdata
);

    // Instruction cache line port
    logic                    ic_req;
    cache_pkg::addr_t        ic_addr;
    logic                    ic_ack;
    cache_pkg::cache_line_u  ic_rdata;

    // Data cache line port
    logic                    dc_req;
    logic                    dc_we;
    cache_pkg::addr_t        dc_addr;
    cache_pkg::cache_line_u  dc_wdata;
    logic                    dc_ack;
    cache_pkg::cache_line_u  dc_rdata;

    // Shared memory port
    logic                    mem_req;
    logic                    mem_we;
    cache_pkg::addr_t        mem_addr;
    cache_pkg::cache_line_u  mem_wdata;
    logic                    mem_ack;
    cache_pkg::cache_line_u  mem_rdata;

    icache #(.ICACHE_LINES(ICACHE_LINES)) icache_inst (.*);

    dcache #(.DCACHE_LINES(DCACHE_LINES)) dcache_inst (.*);

    mem_arbiter mem_arbiter_inst (.*);

    main_mem #(.MEM_LINES(MEM_LINES)) main_mem_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (mem_req),
        .we     (mem_we),
        .addr   (mem_addr),
        .wdata  (mem_wdata),
        .ack    (mem_ack),
        .rdata  (mem_rdata)
    );

endmodule

/* verif/tb_checker.sv */
`timescale 1ns/100ps

module tb_checker (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             i_req,
    input  logic             i_ack,
    input  cache_pkg::word_t i_rdata,
    input  logic             d_req,
    input  logic             d_we,
    input  logic             d_ack,
    input  cache_pkg::word_t d_rdata,
    output int               mismatch_count,
    output int               protocol_count,
    output int               reads_left
);

    localparam int NAME_W = 8 * 32;

    cache_pkg::word_t i_exp_q  [$];
    string            i_name_q [$];
    cache_pkg::word_t d_exp_q  [$];
    string            d_name_q [$];
    logic             i_busy;
    logic             d_busy;

    function automatic string to_text(input logic [NAME_W-1:0] v);
        string s;
        s = "";
        for (int b = NAME_W / 8 - 1; b >= 0; b--) begin
            if (v[b*8 +: 8] != 8'h00) begin
                s = $sformatf("%s%c", s, v[b*8 +: 8]);
            end
        end
        return s;
    endfunction

    // Only reads carry an expected value, kept in file order per port
    task automatic read_expected();
        int               fd;
        int               c;
        logic [7:0]       tok;
        logic [7:0]       op_c;
        cache_pkg::addr_t addr;
        cache_pkg::word_t wdata;
        cache_pkg::word_t expected;
        logic [NAME_W-1:0] name_v;
        fd = $fopen("verif/mem_vectors.txt", "r");
        if (fd == 0) begin
            $display("Checker could not open verif/mem_vectors.txt");
            protocol_count++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                do begin
                    c = $fgetc(fd);
                end while (c != 32'd10 && c != -1);
            end else if ($fscanf(fd, "%s %h %h %h %s", op_c, addr, wdata, expected,
                                 name_v) == 5 && op_c == "R") begin
                if (tok == "I") begin
                    i_exp_q.push_back(expected);
                    i_name_q.push_back(to_text(name_v));
                end else begin
                    d_exp_q.push_back(expected);
                    d_name_q.push_back(to_text(name_v));
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_read(input logic is_data, input cache_pkg::word_t actual);
        cache_pkg::word_t expected;
        string            name;
        if (is_data && d_exp_q.size() > 0) begin
            expected = d_exp_q.pop_front();
            name     = d_name_q.pop_front();
        end else if (!is_data && i_exp_q.size() > 0) begin
            expected = i_exp_q.pop_front();
            name     = i_name_q.pop_front();
        end else begin
            $display("Read answered on the %s port with no expected value left",
                     is_data ? "data" : "instruction");
            protocol_count++;
            return;
        end
        reads_left--;
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    // Sampled at the falling edge, halfway between drive and capture
    initial begin
        mismatch_count = 0;
        protocol_count = 0;
        i_busy         = 1'b0;
        d_busy         = 1'b0;
        read_expected();
        reads_left = i_exp_q.size() + d_exp_q.size();
        forever begin
            @(negedge clk);
            if (!arst_n) begin
                if (i_ack || d_ack) begin
                    $display("An ack was seen while reset was asserted");
                    protocol_count++;
                end
                i_busy = 1'b0;
                d_busy = 1'b0;
            end else begin
                if (i_ack) begin
                    if (!i_busy) begin
                        $display("Instruction ack arrived with no fetch outstanding");
                        protocol_count++;
                    end else begin
                        check_read(1'b0, i_rdata);
                    end
                    i_busy = 1'b0;
                end else if (i_req) begin
                    i_busy = 1'b1;
                end
                if (d_ack) begin
                    if (!d_busy) begin
                        $display("Data ack arrived with no access outstanding");
                        protocol_count++;
                    end else if (!d_we) begin
                        check_read(1'b1, d_rdata);
                    end
                    d_busy = 1'b0;
                end else if (d_req) begin
                    d_busy = 1'b1;
                end
            end
        end
    end

endmodule

/* verif/tb_top.sv */
`timescale 1ns/100ps

module tb_top;

    localparam int MAX_VECS       = 64;
    localparam int RESET_CYCLES   = 8;
    localparam int CYCLES_PER_VEC = 60;

    logic             clk;
    logic             arst_n;
    logic             i_req;
    cache_pkg::addr_t i_addr;
    logic             i_ack;
    cache_pkg::word_t i_rdata;
    logic             d_req;
    logic             d_we;
    cache_pkg::addr_t d_addr;
    cache_pkg::word_t d_wdata;
    logic             d_ack;
    cache_pkg::word_t d_rdata;

    logic [7:0]       vec_port  [MAX_VECS];
    logic [7:0]       vec_op    [MAX_VECS];
    cache_pkg::addr_t vec_addr  [MAX_VECS];
    cache_pkg::word_t vec_wdata [MAX_VECS];
    int               vec_dep   [MAX_VECS];
    int               n_vecs;
    int               d_writes_done;
    int               setup_errors;
    logic             vecs_loaded;
    logic [15:0]      lfsr_i;
    logic [15:0]      lfsr_d;
    int               mismatch_count;
    int               protocol_count;
    int               reads_left;

    mem_subsys_top mem_subsys_top_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .i_req   (i_req),
        .i_addr  (i_addr),
        .i_ack   (i_ack),
        .i_rdata (i_rdata),
        .d_req   (d_req),
        .d_we    (d_we),
        .d_addr  (d_addr),
        .d_wdata (d_wdata),
        .d_ack   (d_ack),
        .d_rdata (d_rdata)
    );

    tb_checker tb_checker_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .i_req          (i_req),
        .i_ack          (i_ack),
        .i_rdata        (i_rdata),
        .d_req          (d_req),
        .d_we           (d_we),
        .d_ack          (d_ack),
        .d_rdata        (d_rdata),
        .mismatch_count (mismatch_count),
        .protocol_count (protocol_count),
        .reads_left     (reads_left)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int draw_idle_cycles(inout logic [15:0] s);
        int n;
        n = 0;
        for (int b = 0; b < 2; b++) begin
            n = (n << 1) | int'(s[0]);
            s = lfsr_step(s);
        end
        return n;
    endfunction

    task automatic load_vectors();
        int                fd;
        int                c;
        int                writes_seen;
        logic [7:0]        tok;
        logic [7:0]        op_c;
        cache_pkg::addr_t  addr;
        cache_pkg::word_t  wdata;
        cache_pkg::word_t  expected;
        logic [8*32-1:0]   name_v;
        n_vecs      = 0;
        writes_seen = 0;
        fd = $fopen("verif/mem_vectors.txt", "r");
        if (fd == 0) begin
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                do begin
                    c = $fgetc(fd);
                end while (c != 32'd10 && c != -1);
            end else if ($fscanf(fd, "%s %h %h %h %s", op_c, addr, wdata, expected,
                                 name_v) == 5 && n_vecs < MAX_VECS) begin
                vec_port[n_vecs]  = tok;
                vec_op[n_vecs]    = op_c;
                vec_addr[n_vecs]  = addr;
                vec_wdata[n_vecs] = wdata;
                // Stores listed earlier that a fetch has to see
                vec_dep[n_vecs]   = writes_seen;
                if (tok == "D" && op_c == "W") begin
                    writes_seen++;
                end
                n_vecs++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_fetches();
        int gap;
        for (int k = 0; k < n_vecs; k++) begin
            if (vec_port[k] == "I") begin
                while (d_writes_done < vec_dep[k]) begin
                    @(posedge clk);
                    #1;
                end
                i_req  = 1'b1;
                i_addr = vec_addr[k];
                do begin
                    @(negedge clk);
                end while (!i_ack);
                @(posedge clk);
                #1;
                i_req = 1'b0;
                gap = draw_idle_cycles(lfsr_i);
                if (gap > 0) begin
                    repeat (gap) @(posedge clk);
                    #1;
                end
            end
        end
    endtask

    task automatic run_data();
        int gap;
        for (int k = 0; k < n_vecs; k++) begin
            if (vec_port[k] == "D") begin
                d_req   = 1'b1;
                d_we    = (vec_op[k] == "W");
                d_addr  = vec_addr[k];
                d_wdata = vec_wdata[k];
                do begin
                    @(negedge clk);
                end while (!d_ack);
                @(posedge clk);
                #1;
                d_req = 1'b0;
                d_we  = 1'b0;
                if (vec_op[k] == "W") begin
                    d_writes_done++;
                end
                gap = draw_idle_cycles(lfsr_d);
                if (gap > 0) begin
                    repeat (gap) @(posedge clk);
                    #1;
                end
            end
        end
    endtask

    initial begin
        arst_n        = 1'b0;
        i_req         = 1'b0;
        i_addr        = '0;
        d_req         = 1'b0;
        d_we          = 1'b0;
        d_addr        = '0;
        d_wdata       = '0;
        lfsr_i        = 16'd41;
        lfsr_d        = 16'd41;
        d_writes_done = 0;
        setup_errors  = 0;
        vecs_loaded   = 1'b0;
        load_vectors();
        vecs_loaded = 1'b1;
        if (n_vecs == 0) begin
            $display("No vectors could be read from verif/mem_vectors.txt");
            setup_errors++;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        // A few quiet cycles so a stray ack after reset is caught
        repeat (2) @(posedge clk);
        #1;
        if (n_vecs > 0) begin
            fork
                run_fetches();
                run_data();
            join
        end
        repeat (4) @(posedge clk);
        $display("Errors: %0d read mismatches, %0d protocol, %0d setup, %0d reads unanswered",
                 mismatch_count, protocol_count, setup_errors, reads_left);
        if (mismatch_count + protocol_count + setup_errors == 0 && reads_left == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Each access is bounded by four memory accesses plus arbitration and idle gaps
    initial begin
        wait (vecs_loaded === 1'b1);
        repeat ((n_vecs + 1) * CYCLES_PER_VEC + RESET_CYCLES) @(posedge clk);
        $display("Timeout: accesses were still pending when the cycle limit ran out");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* mem_subsys.f */
hw/cache_pkg.sv
hw/main_mem.sv
hw/mem_arbiter.sv
hw/icache.sv
hw/dcache.sv
hw/mem_subsys_top.sv
verif/tb_checker.sv
verif/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_top -f mem_subsys.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation binary exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
exit 1

/* verif/mem_vectors.txt */
# port op address wdata expected name
# I fetches, D loads or stores; expected is ignored for stores
D W 00000100 a0a00001 00000000 d_store_w0
D R 00000100 00000000 a0a00001 d_load_w0
D W 00000104 b1b10002 00000000 d_store_w1
D W 00000108 c2c20003 00000000 d_store_w2
D R 00000104 00000000 b1b10002 d_load_neighbour
D W 00000180 d3d30004 00000000 d_store_alias
D R 00000108 00000000 c2c20003 d_load_evicted
D R 00000180 00000000 d3d30004 d_load_alias
D W 00000200 00100093 00000000 d_store_insn0
D W 00000214 00208113 00000000 d_store_insn1
I R 00000200 00000000 00100093 i_fetch_insn0
I R 00000214 00000000 00208113 i_fetch_insn1
D R 00000100 00000000 a0a00001 d_repeat_w0
I R 00000200 00000000 00100093 i_repeat_insn0
D R 00000180 00000000 d3d30004 d_repeat_alias
I R 00000214 00000000 00208113 i_repeat_insn1
D R 00000104 00000000 b1b10002 d_repeat_w1
